// File: list.f
common/io_pkg.sv
rtl/io_bus_ctrl.sv
rtl/uart_bitbang.sv
rtl/led_ctrl.sv
rtl/tick_timer.sv
rtl/io_subsystem.sv
bench/io_subsystem_tb.sv

// File: bench/io_subsystem_tb.sv
module io_subsystem_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned TMR_WIDTH = 16;
   localparam int unsigned TMR_TAP   = 6;

   // Access targets
   localparam int TGT_LED  = 0;
   localparam int TGT_UART = 1;
   localparam int TGT_TMR  = 2;
   localparam int TGT_NONE = 3;

   // Cycles per test, reset included in the total
   localparam int N_RESET = 4;
   localparam int N_LEDUART = 120;
   localparam int N_RX = 100;
   localparam int N_BLUE = 100;
   localparam int N_TMR = 250;
   localparam int N_MIXED = 300;
   localparam int TOTAL_CYCLES = 10 + N_RESET + N_LEDUART + N_RX + (N_BLUE + 2)
                                 + (N_TMR + 1) + N_MIXED;
   localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

   logic            CLK_I;
   logic            reset;
   io_pkg::io_req_t bus_req;
   logic            uart_rx;
   io_pkg::io_rsp_t bus_rsp;
   logic            uart_tx;
   logic            led_red;
   logic            led_green;
   logic            led_blue;
   logic            tmr_flag;

   // Model state, as the registers stand after the last edge
   logic                 m_red;
   logic                 m_green;
   logic                 m_blue;
   logic                 m_bsrc;
   logic                 m_tx;
   logic                 m_rx1;      // RX history, newest first
   logic                 m_rx2;
   logic                 m_tapq;
   logic                 m_flag;
   logic [TMR_WIDTH-1:0] m_cnt;

   logic [31:0] lcg_state;
   logic        rx_drv;            // Level for uart_rx this cycle
   int          checks = 0;
   int          errors = 0;
   int          test_chk0 = 0;
   int          test_err0 = 0;
   int          cycles = 0;

   io_subsystem #(
      .TMR_WIDTH (TMR_WIDTH),
      .TMR_TAP   (TMR_TAP)
   ) dut_i (
      .CLK_I     (CLK_I),
      .reset     (reset),
      .bus_req   (bus_req),
      .uart_rx   (uart_rx),
      .bus_rsp   (bus_rsp),
      .uart_tx   (uart_tx),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue),
      .tmr_flag  (tmr_flag)
   );

   initial begin
      CLK_I = 1'b0;
      forever #5 CLK_I = ~CLK_I;
   end

   // Run limit
   always @(posedge CLK_I) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not complete", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper halves only, low LCG bits repeat quickly
   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], lo[31:16]};
   endfunction

   function automatic io_pkg::io_req_t make_req(input int target, input logic we,
                                                input logic [3:0] sel, input logic [31:0] data);
      io_pkg::io_req_t r;
      r.stb  = 1'b1;
      r.we   = we;
      r.sel  = sel;
      r.adr  = rand_word() & 32'hFFFF_FFE0;   // Decode bits and byte offset clear
      r.wdat = data;
      case (target)
         TGT_LED:  r.adr[io_pkg::LED_ADR_BIT]  = 1'b1;
         TGT_UART: r.adr[io_pkg::UART_ADR_BIT] = 1'b1;
         TGT_TMR:  r.adr[io_pkg::TMR_ADR_BIT]  = 1'b1;
         default:  ;                           // Unmapped
      endcase
      return r;
   endfunction

   task automatic model_reset();
      m_red   = 1'b0;
      m_green = 1'b0;
      m_blue  = 1'b0;
      m_bsrc  = 1'b0;
      m_tx    = 1'b1;                          // Idle line
      m_rx1   = 1'b1;
      m_rx2   = 1'b1;
      m_tapq  = 1'b0;
      m_flag  = 1'b0;
      m_cnt   = '0;
   endtask

   // Expected response, ack with every strobe
   function automatic io_pkg::io_rsp_t model_rsp(input io_pkg::io_req_t req);
      io_pkg::io_rsp_t r;
      r     = '0;
      r.ack = req.stb;
      if (req.stb && req.adr[io_pkg::LED_ADR_BIT])
         r.rdat = {m_bsrc, 28'b0, m_blue, m_green, m_red};
      else if (req.stb && req.adr[io_pkg::UART_ADR_BIT])
         r.rdat[io_pkg::UART_RX_BIT] = m_rx2;  // Two edges old
      else if (req.stb && req.adr[io_pkg::TMR_ADR_BIT])
         r.rdat[TMR_WIDTH-1:0] = m_cnt;
      return r;
   endfunction

   // One clock edge of the model
   task automatic model_step(input io_pkg::io_req_t req, input logic rx);
      logic wr_led;
      logic wr_uart;
      logic wr_tmr;
      logic tap_rise;
      wr_led   = req.stb & req.we & req.adr[io_pkg::LED_ADR_BIT];
      wr_uart  = req.stb & req.we & req.adr[io_pkg::UART_ADR_BIT];
      wr_tmr   = req.stb & req.we & req.adr[io_pkg::TMR_ADR_BIT];
      tap_rise = m_cnt[TMR_TAP] & ~m_tapq;
      if (m_bsrc)                              // Old blue_src decides
         m_blue = ~m_rx2;
      else if (wr_led)
         m_blue = req.wdat.led.blue;
      if (wr_led) begin
         m_red   = req.wdat.led.red;
         m_green = req.wdat.led.green;
         if (req.sel[3])
            m_bsrc = req.wdat.led.blue_src;
      end
      if (wr_uart)
         m_tx = req.wdat.uart.tx;
      m_rx2  = m_rx1;
      m_rx1  = rx;
      m_tapq = m_cnt[TMR_TAP];
      if (wr_tmr)
         m_flag = 1'b0;                        // Write beats a new rise
      else if (tap_rise)
         m_flag = 1'b1;
      m_cnt = wr_tmr ? req.wdat[TMR_WIDTH-1:0] : m_cnt + 1'b1;
   endtask

   task automatic check_rsp(input io_pkg::io_rsp_t got, input io_pkg::io_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED bus_rsp: got ack %h rdat %h, expected ack %h rdat %h",
                  got.ack, got.rdat, exp.ack, exp.rdat);
      end
   endtask

   task automatic check_leds(input logic [2:0] got, input logic [2:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED led_blue/green/red: got %h, expected %h", got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Called at 1 ns after an edge, returns at the same point of the next cycle
   task automatic run_cycle(input io_pkg::io_req_t req);
      bus_req = req;
      uart_rx = rx_drv;
      #4;                                      // Mid-cycle, all settled
      check_rsp(bus_rsp, model_rsp(req));      // Writes too, state before the edge
      check_leds({led_blue, led_green, led_red}, {m_blue, m_green, m_red});
      check_bit("uart_tx", uart_tx, m_tx);
      check_bit("tmr_flag", tmr_flag, m_flag);
      model_step(req, rx_drv);
      @(posedge CLK_I);
      #1;
   endtask

   task automatic start_test();
      test_chk0 = checks;
      test_err0 = errors;
   endtask

   task automatic end_test(input string name);
      $display("test %-14s done, %0d checks, %0d errors", name,
               checks - test_chk0, errors - test_err0);
   endtask

   initial begin : main
      logic [31:0] r;
      lcg_state = 32'd70;
      bus_req   = '0;
      uart_rx   = 1'b1;
      rx_drv    = 1'b1;
      reset     = 1'b1;
      model_reset();
      repeat (10) @(posedge CLK_I);
      #1;
      reset = 1'b0;

      // Outputs and count straight out of reset
      start_test();
      run_cycle('0);
      run_cycle(make_req(TGT_TMR, 1'b0, 4'hF, '0));
      run_cycle(make_req(TGT_TMR, 1'b0, 4'hF, '0));
      run_cycle('0);
      end_test("reset_state");

      start_test();
      for (int i = 0; i < N_LEDUART; i++) begin
         r = rand_word();
         run_cycle(make_req(r[31] ? TGT_UART : TGT_LED, r[30:28] != 3'd0, r[27:24],
                            rand_word()));
      end
      end_test("led_uart_write");

      start_test();
      for (int i = 0; i < N_RX; i++) begin
         r = rand_word();
         if (r[31])
            rx_drv = ~rx_drv;
         run_cycle(make_req(TGT_UART, 1'b0, 4'hF, '0));
      end
      end_test("rx_path");

      // Hand blue to the UART, sel[3] kept low so it stays there
      start_test();
      run_cycle(make_req(TGT_LED, 1'b1, 4'b1000, 32'h8000_0000));
      for (int i = 0; i < N_BLUE; i++) begin
         r = rand_word();
         if (r[31])
            rx_drv = ~rx_drv;
         run_cycle(make_req(TGT_LED, r[30], {1'b0, r[29:27]}, rand_word()));
      end
      run_cycle(make_req(TGT_LED, 1'b1, 4'hF, '0));
      end_test("blue_source");

      // Load just below the tap so the flag comes early
      start_test();
      run_cycle(make_req(TGT_TMR, 1'b1, 4'hF, 32'h0000_0030));
      for (int i = 0; i < N_TMR; i++) begin
         r = rand_word();
         if (r[31:27] == 5'd0)
            run_cycle(make_req(TGT_TMR, 1'b1, 4'hF, rand_word()));
         else
            run_cycle(make_req(TGT_TMR, 1'b0, 4'hF, '0));
      end
      end_test("timer");

      start_test();
      for (int i = 0; i < N_MIXED; i++) begin
         r = rand_word();
         if (r[31])
            rx_drv = ~rx_drv;
         if (r[30:28] == 3'd0)
            run_cycle('0);                     // Idle, no ack expected
         else
            run_cycle(make_req(int'(r[27:26]), r[25], r[24:21], rand_word()));
      end
      end_test("mixed_traffic");

      $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: rtl/io_subsystem.sv
module io_subsystem #(
   parameter int unsigned TMR_WIDTH = io_pkg::TMR_WIDTH_DEF,
   parameter int unsigned TMR_TAP   = 16
) (
   input  logic            CLK_I,
   input  logic            reset,
   input  io_pkg::io_req_t bus_req,
   input  logic            uart_rx,
   output io_pkg::io_rsp_t bus_rsp,
   output logic            uart_tx,
   output logic            led_red,
   output logic            led_green,
   output logic            led_blue,
   output logic            tmr_flag
);

   logic            led_stb;
   logic            uart_stb;
   logic            tmr_stb;
   io_pkg::io_rsp_t led_rsp;
   io_pkg::io_rsp_t uart_rsp;
   io_pkg::io_rsp_t tmr_rsp;
   logic            rx_sync;   // UART to LED, for blue

   // Decode and merge
   io_bus_ctrl bus_ctrl_i (
      .CLK_I    (CLK_I),
      .reset    (reset),
      .bus_req  (bus_req),
      .led_rsp  (led_rsp),
      .uart_rsp (uart_rsp),
      .tmr_rsp  (tmr_rsp),
      .led_stb  (led_stb),
      .uart_stb (uart_stb),
      .tmr_stb  (tmr_stb),
      .bus_rsp  (bus_rsp)
   );

   uart_bitbang uart_i (
      .CLK_I   (CLK_I),
      .reset   (reset),
      .stb     (uart_stb),
      .req     (bus_req),
      .uart_rx (uart_rx),
      .rsp     (uart_rsp),
      .uart_tx (uart_tx),
      .rx_sync (rx_sync)
   );

   led_ctrl led_i (
      .CLK_I     (CLK_I),
      .reset     (reset),
      .stb       (led_stb),
      .req       (bus_req),
      .rx_sync   (rx_sync),
      .rsp       (led_rsp),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue)
   );

   tick_timer #(
      .TMR_WIDTH (TMR_WIDTH),
      .TMR_TAP   (TMR_TAP)
   ) timer_i (
      .CLK_I    (CLK_I),
      .reset    (reset),
      .stb      (tmr_stb),
      .req      (bus_req),
      .rsp      (tmr_rsp),
      .tmr_flag (tmr_flag)
   );

endmodule

// File: rtl/tick_timer.sv
module tick_timer #(
   parameter int unsigned TMR_WIDTH = io_pkg::TMR_WIDTH_DEF,
   parameter int unsigned TMR_TAP   = 16
) (
   input  logic            CLK_I,
   input  logic            reset,
   input  logic            stb,
   input  io_pkg::io_req_t req,
   output io_pkg::io_rsp_t rsp,
   output logic            tmr_flag
);

   logic [TMR_WIDTH-1:0] count;
   logic                 tap_q;      // Tap bit one edge ago
   logic                 tap_rise;
   logic                 wr;
   logic [31:0]          count_ext;

   assign wr = stb & req.we;

   // Free-running count, a write loads it
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         count <= '0;
      end else if (wr) begin
         count <= req.wdat[TMR_WIDTH-1:0];   // Raw word, both views ignored
      end else begin
         count <= count + 1'b1;
      end
   end

   assign tap_rise = count[TMR_TAP] & ~tap_q;

   // Sticky flag, a timer write clears it and wins over a new rise
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         tap_q    <= 1'b0;
         tmr_flag <= 1'b0;
      end else begin
         tap_q <= count[TMR_TAP];
         if (wr)
            tmr_flag <= 1'b0;
         else if (tap_rise)
            tmr_flag <= 1'b1;
      end
   end

   // Zero-extend for narrow counters
   always_comb begin
      count_ext = '0;
      count_ext[TMR_WIDTH-1:0] = count;
   end

   assign rsp.ack  = stb;
   assign rsp.rdat = stb ? count_ext : '0;   // Count of this cycle

endmodule

// File: rtl/led_ctrl.sv
module led_ctrl (
   input  logic            CLK_I,
   input  logic            reset,
   input  logic            stb,
   input  io_pkg::io_req_t req,
   input  logic            rx_sync,
   output io_pkg::io_rsp_t rsp,
   output logic            led_red,
   output logic            led_green,
   output logic            led_blue
);

   logic                 blue_src;   // 1 = blue shows RX activity
   logic                 wr;
   io_pkg::io_led_view_t rd_view;

   assign wr = stb & req.we;

   // Red, green and the blue source bit
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         led_red   <= 1'b0;
         led_green <= 1'b0;
         blue_src  <= 1'b0;
      end else if (wr) begin
         led_red   <= req.wdat.led.red;
         led_green <= req.wdat.led.green;
         if (req.sel[3])       // Top lane carries blue_src
            blue_src <= req.wdat.led.blue_src;
      end
   end

   // Blue is owned by the UART when blue_src is set
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         led_blue <= 1'b0;
      end else if (blue_src) begin
         led_blue <= ~rx_sync;  // Lit while the line is low
      end else if (wr) begin
         led_blue <= req.wdat.led.blue;
      end
   end

   // Read back in the same layout as written
   always_comb begin
      rd_view          = '0;
      rd_view.blue_src = blue_src;
      rd_view.blue     = led_blue;
      rd_view.green    = led_green;
      rd_view.red      = led_red;
   end

   assign rsp.ack  = stb;
   assign rsp.rdat = stb ? rd_view : '0;

   // With RX quiet, a UART-driven blue must hold still
   a_blue_hold: assert property (
      @(posedge CLK_I) disable iff (reset)
      (blue_src && $past(blue_src) && $stable(rx_sync)) |=> $stable(led_blue)
   ) else $error("led_blue moved while driven by a stable RX");

endmodule

// File: rtl/uart_bitbang.sv
module uart_bitbang (
   input  logic            CLK_I,
   input  logic            reset,
   input  logic            stb,
   input  io_pkg::io_req_t req,
   input  logic            uart_rx,
   output io_pkg::io_rsp_t rsp,
   output logic            uart_tx,
   output logic            rx_sync
);

   logic rx_meta;              // First synchroniser stage
   logic wr;
   logic [31:0] rd_word;

   assign wr = stb & req.we;

   // Two flops against metastability, idle line level after reset
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= uart_rx;
         rx_sync <= rx_meta;   // Two edges behind the pin
      end
   end

   // TX register, software drives every bit edge
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         uart_tx <= 1'b1;      // Idle mark
      end else if (wr) begin
         uart_tx <= req.wdat.uart.tx;
      end
   end

   // Read word carries only the RX level
   always_comb begin
      rd_word = '0;
      rd_word[io_pkg::UART_RX_BIT] = rx_sync;
   end

   assign rsp.ack  = stb;      // No wait states
   assign rsp.rdat = stb ? rd_word : '0;

endmodule

// File: rtl/io_bus_ctrl.sv
module io_bus_ctrl (
   input  logic           CLK_I,
   input  logic           reset,
   input  io_pkg::io_req_t bus_req,
   input  io_pkg::io_rsp_t led_rsp,
   input  io_pkg::io_rsp_t uart_rsp,
   input  io_pkg::io_rsp_t tmr_rsp,
   output logic           led_stb,
   output logic           uart_stb,
   output logic           tmr_stb,
   output io_pkg::io_rsp_t bus_rsp
);

   logic [2:0] hit;            // Mapped address bits, one per peripheral
   logic       unmapped_stb;   // Strobe hitting no peripheral
   logic       merged_ack;
   logic [31:0] merged_rdat;

   // Pick the one-hot decode bits out of the address
   assign hit[0] = bus_req.adr[io_pkg::LED_ADR_BIT];
   assign hit[1] = bus_req.adr[io_pkg::UART_ADR_BIT];
   assign hit[2] = bus_req.adr[io_pkg::TMR_ADR_BIT];

   // Strobe fan-out
   assign led_stb  = bus_req.stb & hit[0];
   assign uart_stb = bus_req.stb & hit[1];
   assign tmr_stb  = bus_req.stb & hit[2];

   // Nobody home, answer here so the master never hangs
   assign unmapped_stb = bus_req.stb & ~(|hit);

   // Peripherals gate their own read data, a plain OR merges them
   always_comb begin
      merged_ack  = led_rsp.ack | uart_rsp.ack | tmr_rsp.ack;
      merged_ack  = merged_ack | unmapped_stb;   // Default response
      merged_rdat = led_rsp.rdat | uart_rsp.rdat | tmr_rsp.rdat;
   end

   assign bus_rsp.ack  = merged_ack;
   assign bus_rsp.rdat = merged_rdat;   // Zero on unmapped accesses

   // Two peripherals selected at once is a software bug
   a_onehot_decode: assert property (
      @(posedge CLK_I) disable iff (reset)
      bus_req.stb |-> $onehot0(hit)
   ) else $error("more than one mapped address bit set, adr %h", bus_req.adr);

   // Every access is answered in its own cycle, and nothing else is
   a_ack_follows_stb: assert property (
      @(posedge CLK_I) disable iff (reset)
      bus_rsp.ack == bus_req.stb
   ) else $error("ack %b does not match stb %b", bus_rsp.ack, bus_req.stb);

   // No stray read data without an ack
   a_rdat_quiet: assert property (
      @(posedge CLK_I) disable iff (reset)
      !bus_req.stb |-> (bus_rsp.rdat == '0)
   ) else $error("read data %h without strobe", bus_rsp.rdat);

endmodule

// File: common/io_pkg.sv
// Shared types and constants of the memory-mapped I/O subsystem
package io_pkg;

   // One-hot address decode, one bit per peripheral
   localparam int unsigned LED_ADR_BIT  = 2;
   localparam int unsigned UART_ADR_BIT = 3;
   localparam int unsigned TMR_ADR_BIT  = 4;

   // UART read word, RX level here and zero elsewhere
   localparam int unsigned UART_RX_BIT = 8;

   // Default tick counter width
   localparam int unsigned TMR_WIDTH_DEF = 32;

   // LED view of the data word, also the LED read layout
   typedef struct packed {
      logic        blue_src;   // 1 = blue follows inverted RX
      logic [27:0] unused;
      logic        blue;
      logic        green;
      logic        red;
   } io_led_view_t;

   // UART view of the data word
   typedef struct packed {
      logic [30:0] unused;
      logic        tx;         // Line level to drive
   } io_uart_view_t;

   // Write data as seen by the LED register and the UART
   typedef union packed {
      io_led_view_t  led;
      io_uart_view_t uart;
   } io_wdata_u;

   // Bus request from the core, held for one cycle per access
   typedef struct packed {
      logic        stb;
      logic        we;
      logic [3:0]  sel;        // Byte lanes
      logic [31:0] adr;
      io_wdata_u   wdat;
   } io_req_t;

   // Response, ack in the same cycle as stb
   typedef struct packed {
      logic        ack;
      logic [31:0] rdat;       // Zero when not acked
   } io_rsp_t;

endpackage
